/* cache_cfg_pkg.sv */
package cache_cfg_pkg;

  // Address geometry
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W = WORD_W * WORDS_PER_LINE;
  localparam int BYTE_OFF_W = 2;
  localparam int WORD_OFF_W = 2;
  localparam int OFFSET_W = WORD_OFF_W + BYTE_OFF_W;
  localparam int TAG_W = ADDR_W - OFFSET_W;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [WORD_OFF_W-1:0] word_off_t;
  typedef logic [BYTE_OFF_W-1:0] byte_off_t;

  typedef enum logic {
    CPU_READ,
    CPU_WRITE
  } cpu_op_t;

  // CPU request, held by the CPU until done
  typedef struct packed {
    cpu_op_t op;
    // Byte access, lane picked by addr
    logic    byte_op;
    addr_t   addr;
    // Byte writes use the low byte only
    word_t   wdata;
  } cpu_req_t;

  // Field extraction from a byte address
  function automatic tag_t tag_of(addr_t addr);
    return addr[ADDR_W-1:OFFSET_W];
  endfunction

  function automatic word_off_t word_of(addr_t addr);
    return addr[OFFSET_W-1:BYTE_OFF_W];
  endfunction

  function automatic byte_off_t byte_of(addr_t addr);
    return addr[BYTE_OFF_W-1:0];
  endfunction

endpackage

/* cache_mem_pkg.sv */
package cache_mem_pkg;

  // Memory port opcodes
  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_t;

  // One request per credit
  // Reads return a full line later on mem_rsp_valid
  // Writes carry the evicted line and get no response
  typedef struct packed {
    mem_op_t              op;
    // Line address, offset bits dropped
    cache_cfg_pkg::tag_t  tag;
    // Only meaningful for MEM_WRITE
    cache_cfg_pkg::line_t wdata;
  } mem_req_t;

endpackage

/* tag_lookup.sv */
`timescale 1ns/1ps

module tag_lookup #(
  parameter int NUM_LINES = 4,
  localparam int WAY_W = $clog2(NUM_LINES)
) (
  input  cache_cfg_pkg::tag_t                 lookup_tag,
  input  cache_cfg_pkg::tag_t [NUM_LINES-1:0] line_tags,
  input  logic [NUM_LINES-1:0]                line_valid,
  output logic                                hit,
  output logic [WAY_W-1:0]                    hit_way
);

  typedef logic [WAY_W-1:0] way_t;

  // One comparator per line
  logic [NUM_LINES-1:0] match;

  always_comb
  begin
    for (int i = 0; i < NUM_LINES; i++)
    begin
      // Invalid lines never match, whatever their stale tag
      match[i] = line_valid[i] && (line_tags[i] == lookup_tag);
    end
  end

  assign hit = |match;

  // Priority encoder, lowest matching way wins
  // Scanning downwards lets the last write be the lowest index
  always_comb
  begin
    hit_way = '0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (match[i])
      begin
        hit_way = way_t'(i);
      end
    end
  end

endmodule

/* lru_tracker.sv */
`timescale 1ns/1ps

module lru_tracker #(
  parameter int NUM_LINES = 4,
  localparam int WAY_W = $clog2(NUM_LINES)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             touch_valid,
  input  logic [WAY_W-1:0] touch_way,
  output logic [WAY_W-1:0] victim_way
);

  typedef logic [WAY_W-1:0] way_t;
  // Ages run 0..NUM_LINES-1, so they fit in a way index
  typedef logic [WAY_W-1:0] age_t;

  // Highest age is the most recent line
  age_t age [NUM_LINES];
  age_t touched_age;

  assign touched_age = age[touch_way];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      // Line i starts at age i, a valid permutation
      for (int i = 0; i < NUM_LINES; i++)
      begin
        age[i] <= age_t'(i);
      end
    end
    else if (touch_valid)
    begin
      for (int i = 0; i < NUM_LINES; i++)
      begin
        // Younger lines slide down one step to fill the gap
        if (age[i] > touched_age)
        begin
          age[i] <= age[i] - 1'b1;
        end
      end
      age[touch_way] <= age_t'(NUM_LINES - 1);
    end
  end

  // Victim is the single line at age zero
  always_comb
  begin
    victim_way = '0;
    for (int i = 0; i < NUM_LINES; i++)
    begin
      if (age[i] == '0)
      begin
        victim_way = way_t'(i);
      end
    end
  end

endmodule

/* cache_controller.sv */
`timescale 1ns/1ps

module cache_controller #(
  parameter int NUM_LINES = 4,
  parameter int MEM_CREDITS = 2,
  localparam int WAY_W = $clog2(NUM_LINES),
  localparam int CRED_W = $clog2(MEM_CREDITS + 1)
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cpu_req_valid,
  input  cache_cfg_pkg::cpu_req_t             cpu_req,
  output logic                                cpu_done,
  output cache_cfg_pkg::word_t                cpu_rdata,
  output logic                                cpu_hit,
  output cache_cfg_pkg::tag_t                 lookup_tag,
  output cache_cfg_pkg::tag_t [NUM_LINES-1:0] line_tags,
  output logic [NUM_LINES-1:0]                line_valid,
  input  logic                                hit,
  input  logic [WAY_W-1:0]                    hit_way,
  output logic                                touch_valid,
  output logic [WAY_W-1:0]                    touch_way,
  input  logic [WAY_W-1:0]                    victim_way,
  output logic                                mem_req_valid,
  output cache_mem_pkg::mem_req_t             mem_req,
  input  logic                                mem_credit,
  input  logic                                mem_rsp_valid,
  input  cache_cfg_pkg::line_t                mem_rsp_data
);

  typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, FETCH, WAIT_FILL, DONE} state_t;
  typedef logic [WAY_W-1:0] way_t;
  typedef logic [CRED_W-1:0] credit_t;

  state_t                  state;
  cache_cfg_pkg::cpu_req_t req_q;
  way_t                    victim_q;
  credit_t                 credit_cnt;
  logic [NUM_LINES-1:0]    dirty_q;
  cache_cfg_pkg::line_t    data_mem [NUM_LINES];
  logic                    is_write;
  logic                    fill;

  // Pending write merged into a line, word or single byte
  function automatic cache_cfg_pkg::line_t merge_line(cache_cfg_pkg::line_t line,
                                                      cache_cfg_pkg::cpu_req_t req);
    cache_cfg_pkg::line_t merged;
    int                   wpos;
    merged = line;
    wpos = int'(cache_cfg_pkg::word_of(req.addr)) * cache_cfg_pkg::WORD_W;
    if (req.byte_op)
      merged[wpos + int'(cache_cfg_pkg::byte_of(req.addr)) * 8 +: 8] = req.wdata[7:0];
    else
      merged[wpos +: cache_cfg_pkg::WORD_W] = req.wdata;
    return merged;
  endfunction

  // Read data, byte reads zero-extended
  function automatic cache_cfg_pkg::word_t read_word(cache_cfg_pkg::line_t line,
                                                     cache_cfg_pkg::cpu_req_t req);
    cache_cfg_pkg::word_t word;
    word = line[int'(cache_cfg_pkg::word_of(req.addr)) * cache_cfg_pkg::WORD_W +:
                cache_cfg_pkg::WORD_W];
    if (req.byte_op)
      word = {24'b0, word[int'(cache_cfg_pkg::byte_of(req.addr)) * 8 +: 8]};
    return word;
  endfunction

  assign is_write = (req_q.op == cache_cfg_pkg::CPU_WRITE);
  assign lookup_tag = cache_cfg_pkg::tag_of(req_q.addr);
  assign fill = (state == WAIT_FILL) && mem_rsp_valid;

  // One touch per access, on the hit or on the refill
  assign touch_valid = ((state == LOOKUP) && hit) || fill;
  assign touch_way = (state == LOOKUP) ? hit_way : victim_q;

  // Issue only while a credit is held
  assign mem_req_valid = ((state == EVICT) || (state == FETCH)) && (credit_cnt != '0);
  assign mem_req.op = (state == EVICT) ? cache_mem_pkg::MEM_WRITE : cache_mem_pkg::MEM_READ;
  // Write-back uses the victim's old tag, fetch the requested one
  assign mem_req.tag = (state == EVICT) ? line_tags[victim_q] : lookup_tag;
  assign mem_req.wdata = data_mem[victim_q];

  // Control state and credit counter
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= IDLE;
      cpu_done <= 1'b0;
      cpu_hit <= 1'b0;
      line_valid <= '0;
      dirty_q <= '0;
      credit_cnt <= credit_t'(MEM_CREDITS);
    end
    else
    begin
      cpu_done <= 1'b0;
      // Credits tracked regardless of state
      credit_cnt <= credit_cnt - credit_t'(mem_req_valid) + credit_t'(mem_credit);
      case (state)
        IDLE:
        begin
          // Request still high during the done cycle is the old one
          if (cpu_req_valid && !cpu_done)
            state <= LOOKUP;
        end
        LOOKUP:
        begin
          cpu_hit <= hit;
          if (hit)
          begin
            if (is_write)
              dirty_q[hit_way] <= 1'b1;
            state <= DONE;
          end
          else if (line_valid[victim_way] && dirty_q[victim_way])
            state <= EVICT;
          else
            state <= FETCH;
        end
        EVICT:
        begin
          if (mem_req_valid)
            state <= FETCH;
        end
        FETCH:
        begin
          if (mem_req_valid)
            state <= WAIT_FILL;
        end
        WAIT_FILL:
        begin
          if (mem_rsp_valid)
          begin
            line_valid[victim_q] <= 1'b1;
            // Refilled line is dirty only if the pending write lands in it
            dirty_q[victim_q] <= is_write;
            state <= DONE;
          end
        end
        DONE:
        begin
          cpu_done <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request latch, tags, line data and read data
  always_ff @(posedge clk)
  begin
    if (state == IDLE)
      req_q <= cpu_req;
    if (state == LOOKUP)
    begin
      // Victim frozen here, the tracker moves on the touch
      victim_q <= victim_way;
      if (hit)
      begin
        cpu_rdata <= read_word(data_mem[hit_way], req_q);
        if (is_write)
          data_mem[hit_way] <= merge_line(data_mem[hit_way], req_q);
      end
    end
    if (fill)
    begin
      line_tags[victim_q] <= lookup_tag;
      cpu_rdata <= read_word(mem_rsp_data, req_q);
      data_mem[victim_q] <= is_write ? merge_line(mem_rsp_data, req_q) : mem_rsp_data;
    end
  end

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
  parameter int NUM_LINES = 4,
  parameter int MEM_CREDITS = 2
) (
  input  logic                    clk,
  input  logic                    reset,
  // CPU port
  input  logic                    cpu_req_valid,
  input  cache_cfg_pkg::cpu_req_t cpu_req,
  output logic                    cpu_done,
  output cache_cfg_pkg::word_t    cpu_rdata,
  output logic                    cpu_hit,
  // Memory port, credit based
  output logic                    mem_req_valid,
  output cache_mem_pkg::mem_req_t mem_req,
  input  logic                    mem_credit,
  input  logic                    mem_rsp_valid,
  input  cache_cfg_pkg::line_t    mem_rsp_data
);

  localparam int WAY_W = $clog2(NUM_LINES);

  cache_cfg_pkg::tag_t                 lookup_tag;
  cache_cfg_pkg::tag_t [NUM_LINES-1:0] line_tags;
  logic [NUM_LINES-1:0]                line_valid;
  logic                                hit;
  logic [WAY_W-1:0]                    hit_way;
  logic                                touch_valid;
  logic [WAY_W-1:0]                    touch_way;
  logic [WAY_W-1:0]                    victim_way;

  // Parallel compare of all stored tags
  tag_lookup #(
    .NUM_LINES(NUM_LINES)
  ) u_lookup (
    .lookup_tag (lookup_tag),
    .line_tags  (line_tags),
    .line_valid (line_valid),
    .hit        (hit),
    .hit_way    (hit_way)
  );

  // Replacement choice, runs beside the lookup
  lru_tracker #(
    .NUM_LINES(NUM_LINES)
  ) u_lru (
    .clk         (clk),
    .reset       (reset),
    .touch_valid (touch_valid),
    .touch_way   (touch_way),
    .victim_way  (victim_way)
  );

  cache_controller #(
    .NUM_LINES   (NUM_LINES),
    .MEM_CREDITS (MEM_CREDITS)
  ) u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_done      (cpu_done),
    .cpu_rdata     (cpu_rdata),
    .cpu_hit       (cpu_hit),
    .lookup_tag    (lookup_tag),
    .line_tags     (line_tags),
    .line_valid    (line_valid),
    .hit           (hit),
    .hit_way       (hit_way),
    .touch_valid   (touch_valid),
    .touch_way     (touch_way),
    .victim_way    (victim_way),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

endmodule

/* cache_checker.sv */
`timescale 1ns/1ps

module cache_checker #(
  parameter int MEM_CREDITS = 2
) (
  input logic clk,
  input logic reset,
  input logic cpu_req_valid,
  input logic cpu_done,
  input logic mem_req_valid,
  input logic mem_credit
);

  // Requests issued but not yet paid back with a credit
  int outstanding;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(mem_req_valid) - int'(mem_credit);
  end

  // Quiet ports while reset is held
  reset_quiet: assert property (@(posedge clk) reset |-> (!mem_req_valid && !cpu_done))
    else $error("cache port active during reset");

  credit_limit: assert property (@(posedge clk) disable iff (reset)
    outstanding <= MEM_CREDITS)
    else $error("more memory requests in flight than credits");

  // An issue needs a credit in hand
  issue_with_credit: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> (outstanding < MEM_CREDITS))
    else $error("memory request issued without a credit");

  // Done only answers a request held since before
  done_after_request: assert property (@(posedge clk) disable iff (reset)
    cpu_done |-> (cpu_req_valid && $past(cpu_req_valid)))
    else $error("cpu_done without a held request");

  done_is_pulse: assert property (@(posedge clk) disable iff (reset)
    cpu_done |=> !cpu_done)
    else $error("cpu_done held longer than one cycle");

endmodule

bind cache_top cache_checker #(
  .MEM_CREDITS(MEM_CREDITS)
) u_checker (
  .clk           (clk),
  .reset         (reset),
  .cpu_req_valid (cpu_req_valid),
  .cpu_done      (cpu_done),
  .mem_req_valid (mem_req_valid),
  .mem_credit    (mem_credit)
);

/* tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    mem_req_valid,
  input  cache_mem_pkg::mem_req_t mem_req,
  output logic                    mem_credit,
  output logic                    mem_rsp_valid,
  output cache_cfg_pkg::line_t    mem_rsp_data,
  output int                      write_count
);

  // Lines written back so far, all others still hold the initial pattern
  cache_cfg_pkg::line_t lines [cache_cfg_pkg::tag_t];
  // Cycle stamps at which credits and read data fall due
  int                   credit_due [$];
  int                   rsp_due [$];
  cache_cfg_pkg::line_t rsp_line [$];
  int                   cycle;

  // Initial content is each word's byte address XOR a fixed pattern
  function automatic cache_cfg_pkg::line_t line_at(cache_cfg_pkg::tag_t tag);
    cache_cfg_pkg::line_t line;
    logic [31:0]          addr;
    if (lines.exists(tag))
      return lines[tag];
    for (int w = 0; w < 4; w++)
    begin
      addr = {tag, 4'(w * 4)};
      line[w*32 +: 32] = addr ^ 32'hA5A5_0000;
    end
    return line;
  endfunction

  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mem_credit <= 1'b0;
      mem_rsp_valid <= 1'b0;
      mem_rsp_data <= '0;
      write_count <= 0;
      cycle = 0;
      credit_due.delete();
      rsp_due.delete();
      rsp_line.delete();
    end
    else
    begin
      cycle = cycle + 1;
      mem_credit <= 1'b0;
      mem_rsp_valid <= 1'b0;
      if (mem_req_valid)
      begin
        // Every consumed request pays back one credit later
        credit_due.push_back(cycle + int'($urandom_range(6, 1)));
        if (mem_req.op == cache_mem_pkg::MEM_WRITE)
        begin
          lines[mem_req.tag] = mem_req.wdata;
          write_count <= write_count + 1;
        end
        else
        begin
          // Read data captured now, delivered after its delay
          rsp_due.push_back(cycle + int'($urandom_range(6, 1)));
          rsp_line.push_back(line_at(mem_req.tag));
        end
      end
      // At most one credit pulse per cycle
      if (credit_due.size() > 0 && credit_due[0] <= cycle)
      begin
        mem_credit <= 1'b1;
        void'(credit_due.pop_front());
      end
      if (rsp_due.size() > 0 && rsp_due[0] <= cycle)
      begin
        mem_rsp_valid <= 1'b1;
        mem_rsp_data <= rsp_line.pop_front();
        void'(rsp_due.pop_front());
      end
    end
  end

endmodule

/* tb_cache_top.sv */
`timescale 1ns/1ps

module tb_cache_top;

  localparam int NUM_LINES = 4;
  localparam int MEM_CREDITS = 2;
  // Cycles allowed for one access with two memory trips
  localparam int TIMEOUT = 200;

  logic                    clk;
  logic                    reset;
  logic                    cpu_req_valid;
  cache_cfg_pkg::cpu_req_t cpu_req;
  logic                    cpu_done;
  cache_cfg_pkg::word_t    cpu_rdata;
  logic                    cpu_hit;
  logic                    mem_req_valid;
  cache_mem_pkg::mem_req_t mem_req;
  logic                    mem_credit;
  logic                    mem_rsp_valid;
  cache_cfg_pkg::line_t    mem_rsp_data;
  int                      write_count;

  // Shadow memory keyed by word-aligned address
  // Absent words keep the initial pattern
  cache_cfg_pkg::word_t shadow [cache_cfg_pkg::addr_t];
  // Cached lines in recency order with the least recent first
  cache_cfg_pkg::tag_t  lru_q [$];
  bit                   dirty_m [cache_cfg_pkg::tag_t];
  int                   exp_writes;

  cache_top #(
    .NUM_LINES   (NUM_LINES),
    .MEM_CREDITS (MEM_CREDITS)
  ) uut (
    .clk           (clk),
    .reset         (reset),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_done      (cpu_done),
    .cpu_rdata     (cpu_rdata),
    .cpu_hit       (cpu_hit),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  tb_mem_model u_mem (
    .clk           (clk),
    .reset         (reset),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .write_count   (write_count)
  );

  always #10 clk = ~clk;

  function automatic cache_cfg_pkg::word_t word_at(cache_cfg_pkg::addr_t addr);
    cache_cfg_pkg::addr_t wa;
    wa = {addr[31:2], 2'b00};
    if (shadow.exists(wa))
      return shadow[wa];
    return wa ^ 32'hA5A5_0000;
  endfunction

  // Recency list update that returns whether the line was already cached
  function automatic bit lru_access(cache_cfg_pkg::tag_t tag, bit is_write);
    int                  idx;
    cache_cfg_pkg::tag_t old;
    idx = -1;
    foreach (lru_q[i])
      if (lru_q[i] == tag)
        idx = i;
    if (idx >= 0)
      lru_q.delete(idx);
    else
    begin
      // Full cache drops its least recent line and writes it back if dirty
      if (lru_q.size() == NUM_LINES)
      begin
        old = lru_q.pop_front();
        if (dirty_m[old])
          exp_writes++;
        dirty_m.delete(old);
      end
      dirty_m[tag] = 1'b0;
    end
    if (is_write)
      dirty_m[tag] = 1'b1;
    lru_q.push_back(tag);
    return idx >= 0;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_timeout(cache_cfg_pkg::addr_t addr);
    $display("Access to address 0x%h never finished, cpu_done did not arrive", addr);
    $display("STATUS: FAIL");
    $fatal(1, "access timeout");
  endtask

  // One CPU access checked against the shadow and LRU models
  task automatic access(bit write, bit byte_op, cache_cfg_pkg::addr_t addr,
                        cache_cfg_pkg::word_t wdata);
    cache_cfg_pkg::cpu_req_t req;
    cache_cfg_pkg::word_t    word;
    cache_cfg_pkg::word_t    exp_rdata;
    bit                      exp_hit;
    int                      cycles;
    // Word accesses ignore the byte bits
    if (!byte_op)
      addr[1:0] = 2'b00;
    word = word_at(addr);
    exp_rdata = byte_op ? {24'b0, word[int'(addr[1:0])*8 +: 8]} : word;
    exp_hit = lru_access(addr[31:4], write);
    if (write)
    begin
      if (byte_op)
        word[int'(addr[1:0])*8 +: 8] = wdata[7:0];
      else
        word = wdata;
      shadow[{addr[31:2], 2'b00}] = word;
    end
    req.op = write ? cache_cfg_pkg::CPU_WRITE : cache_cfg_pkg::CPU_READ;
    req.byte_op = byte_op;
    req.addr = addr;
    req.wdata = wdata;
    @(posedge clk);
    cpu_req_valid <= 1'b1;
    cpu_req <= req;
    cycles = 0;
    @(negedge clk);
    while (!cpu_done)
    begin
      if (cycles >= TIMEOUT)
        report_timeout(addr);
      cycles++;
      @(negedge clk);
    end
    if (cpu_hit !== exp_hit)
      report_mismatch("cpu_hit", 32'(exp_hit), 32'(cpu_hit));
    if (!write && cpu_rdata !== exp_rdata)
      report_mismatch("cpu_rdata", exp_rdata, cpu_rdata);
    // Write-backs only for dirty victims
    if (write_count !== exp_writes)
      report_mismatch("mem write count", exp_writes, write_count);
  endtask

  initial
  begin
    int k;
    cache_cfg_pkg::addr_t addr;
    void'($urandom(32'h4f0f9bf2));
    clk = 1'b0;
    reset = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req = '0;
    exp_writes = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    // Read miss then hits in the same line
    access(0, 0, 32'h0000_0100, 0);
    access(0, 0, 32'h0000_0108, 0);
    access(0, 1, 32'h0000_0103, 0);
    // Word and byte writes on hits and on misses
    access(1, 0, 32'h0000_0104, 32'hDEAD_BEEF);
    access(1, 1, 32'h0000_0105, 32'h0000_0077);
    access(1, 0, 32'h0000_0210, 32'h1234_5678);
    access(1, 1, 32'h0000_0323, 32'h0000_00C3);
    access(0, 0, 32'h0000_0104, 0);
    access(0, 1, 32'h0000_0105, 0);
    access(0, 0, 32'h0000_0320, 0);
    access(0, 1, 32'h0000_0323, 0);
    // Random traffic over two more lines than the cache holds
    repeat (80)
    begin
      k = int'($urandom_range(NUM_LINES + 1, 0));
      addr = 32'h0000_4000 + k * 16 + ($urandom & 15);
      access($urandom & 1, $urandom & 1, addr, $urandom);
    end
    // Earlier dirty lines come back from memory
    access(0, 0, 32'h0000_0104, 0);
    access(0, 1, 32'h0000_0105, 0);
    access(0, 0, 32'h0000_0210, 0);
    access(0, 1, 32'h0000_0323, 0);
    @(posedge clk);
    cpu_req_valid <= 1'b0;
    // Let the last credits come home
    repeat (20) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* build.f */
cache_cfg_pkg.sv
cache_mem_pkg.sv
tag_lookup.sv
lru_tracker.sv
cache_controller.sv
cache_top.sv
cache_checker.sv
tb_mem_model.sv
tb_cache_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cache_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# First assertion error ends the run with a nonzero status
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
